// File: Bender.yml
package:
  name: pt_dma_shim

sources:
  - files:
      - src/pt_dma_pkg.sv
      - src/pt_read_injector.sv
      - src/pt_write_injector.sv
      - src/afu_tag_checker.sv
      - src/host_rsp_steer.sv
      - src/pt_dma_shim.sv
  - target: test
    files:
      - tests/tb_pt_dma_shim.sv

// File: compile.f
src/pt_dma_pkg.sv
src/pt_read_injector.sv
src/pt_write_injector.sv
src/afu_tag_checker.sv
src/host_rsp_steer.sv
src/pt_dma_shim.sv
tests/tb_pt_dma_shim.sv

// File: src/afu_tag_checker.sv
`default_nettype none

module afu_tag_checker (
    input  logic                clk,
    input  logic                reset_n,
    input  pt_dma_pkg::c0_req_t afu_c0_req,
    input  pt_dma_pkg::c1_req_t afu_c1_req,
    output logic                tag_error
);
    import pt_dma_pkg::*;

    logic c0_bad;
    logic c1_bad;

    // ==============================
    // Decode
    // ==============================

    // A response to a request carrying the reserved tag would be steered to
    // the page-table client, so such a request is a protocol violation by
    // the AFU. Only valid requests count
    assign c0_bad = afu_c0_req.valid && is_reserved_tag(afu_c0_req.mdata);
    assign c1_bad = afu_c1_req.valid && is_reserved_tag(afu_c1_req.mdata);

    // ==============================
    // Sticky error
    // ==============================

    // Once set the error holds until reset. The top level uses it to force
    // both almost-full outputs high and so stop further AFU traffic
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tag_error <= 1'b0;
        end
        else if (c0_bad || c1_bad)
        begin
            tag_error <= 1'b1;
        end
    end

    // The error is visible one cycle after the offending request, which is
    // too late to drop that request itself. It still reaches the host

endmodule

`default_nettype wire

// File: src/host_rsp_steer.sv
`default_nettype none

module host_rsp_steer (
    input  pt_dma_pkg::c0_rsp_t    host_c0_rsp,
    input  pt_dma_pkg::c1_rsp_t    host_c1_rsp,
    output pt_dma_pkg::pt_rd_rsp_t pt_rd_rsp,
    output pt_dma_pkg::c0_rsp_t    afu_c0_rsp,
    output pt_dma_pkg::c1_rsp_t    afu_c1_rsp
);
    import pt_dma_pkg::*;

    logic c0_is_pt;
    logic c1_is_pt;

    // ==============================
    // Classify
    // ==============================

    // A response belongs to the shim when its mdata carries the reserved tag.
    // The AFU is never allowed to use it, so there is no ambiguity
    assign c0_is_pt = is_reserved_tag(host_c0_rsp.mdata);
    assign c1_is_pt = is_reserved_tag(host_c1_rsp.mdata);

    // ==============================
    // Read responses
    // ==============================

    always_comb
    begin
        // Data and tag go to the client every cycle, valid qualifies them
        pt_rd_rsp.valid = host_c0_rsp.valid && c0_is_pt;
        pt_rd_rsp.tag   = host_c0_rsp.mdata[PT_TAG_W-1:0];
        pt_rd_rsp.data  = host_c0_rsp.data;

        // The AFU sees everything else unchanged
        afu_c0_rsp = host_c0_rsp;
        if (c0_is_pt)
        begin
            afu_c0_rsp.valid = 1'b0;
        end
    end

    // ==============================
    // Write responses
    // ==============================

    // Shim writes need no completion report, so their responses just vanish
    always_comb
    begin
        afu_c1_rsp = host_c1_rsp;
        if (c1_is_pt)
        begin
            afu_c1_rsp.valid = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: src/pt_dma_pkg.sv
`default_nettype none

package pt_dma_pkg;

    // ==============================
    // Widths
    // ==============================

    // Cache-line address as seen on the host request channels
    localparam int CL_ADDR_W = 42;

    // One line of data, kept narrow in this shim
    localparam int LINE_DATA_W = 64;

    // Metadata carried with each request and returned on its response
    localparam int MDATA_W = 16;

    // The page-table client's own tag lives in the low bits of mdata
    localparam int PT_TAG_W = 8;

    // ==============================
    // Reserved tag
    // ==============================

    // The top mdata bit marks shim traffic. The AFU must never set it
    localparam logic [MDATA_W-1:0] MDATA_TAG_MASK = 16'h8000;

    // Value of the masked bits on shim traffic. It sets every masked bit and
    // nothing outside the mask, so a tagged response can always be recognized
    localparam logic [MDATA_W-1:0] MDATA_TAG_VALUE = MDATA_TAG_MASK;

    // ==============================
    // Enums
    // ==============================

    // Request opcodes used on c0 (reads) and c1 (writes)
    typedef enum logic [0:0] {
        OP_RD_LINE = 1'b0,
        OP_WR_LINE = 1'b1
    } req_op_e;

    // Both injectors hold at most one request
    typedef enum logic [0:0] {
        INJ_IDLE    = 1'b0,
        INJ_PENDING = 1'b1
    } inj_state_e;

    // ==============================
    // Channel structs
    // ==============================

    typedef struct packed {
        logic                 valid;
        req_op_e              op;
        logic [CL_ADDR_W-1:0] addr;
        logic [MDATA_W-1:0]   mdata;
    } c0_req_t;

    typedef struct packed {
        logic                   valid;
        req_op_e                op;
        logic [CL_ADDR_W-1:0]   addr;
        logic [MDATA_W-1:0]     mdata;
        logic [LINE_DATA_W-1:0] data;
    } c1_req_t;

    typedef struct packed {
        logic                   valid;
        logic [MDATA_W-1:0]     mdata;
        logic [LINE_DATA_W-1:0] data;
    } c0_rsp_t;

    typedef struct packed {
        logic               valid;
        logic [MDATA_W-1:0] mdata;
    } c1_rsp_t;

    // Page-table client side. Requests carry no valid because the enables
    // travel as separate strobes
    typedef struct packed {
        logic [CL_ADDR_W-1:0] addr;
        logic [PT_TAG_W-1:0]  tag;
    } pt_rd_req_t;

    typedef struct packed {
        logic [CL_ADDR_W-1:0]   addr;
        logic [LINE_DATA_W-1:0] data;
    } pt_wr_req_t;

    typedef struct packed {
        logic                   valid;
        logic [PT_TAG_W-1:0]    tag;
        logic [LINE_DATA_W-1:0] data;
    } pt_rd_rsp_t;

    // True when the masked mdata bits identify shim traffic
    function automatic logic is_reserved_tag(input logic [MDATA_W-1:0] mdata);
        return (mdata & MDATA_TAG_MASK) == MDATA_TAG_VALUE;
    endfunction

endpackage

`default_nettype wire

// File: src/pt_dma_shim.sv
`default_nettype none

module pt_dma_shim (
    input  logic                   clk,
    input  logic                   reset_n,

    // AFU side
    input  pt_dma_pkg::c0_req_t    afu_c0_req,
    input  pt_dma_pkg::c1_req_t    afu_c1_req,
    output pt_dma_pkg::c0_rsp_t    afu_c0_rsp,
    output pt_dma_pkg::c1_rsp_t    afu_c1_rsp,
    output logic                   afu_c0_alm_full,
    output logic                   afu_c1_alm_full,

    // Host side
    output pt_dma_pkg::c0_req_t    host_c0_req,
    output pt_dma_pkg::c1_req_t    host_c1_req,
    input  pt_dma_pkg::c0_rsp_t    host_c0_rsp,
    input  pt_dma_pkg::c1_rsp_t    host_c1_rsp,
    input  logic                   host_c0_alm_full,
    input  logic                   host_c1_alm_full,

    // Page-table client
    input  logic                   pt_rd_en,
    input  pt_dma_pkg::pt_rd_req_t pt_rd_req,
    output logic                   pt_rd_rdy,
    input  logic                   pt_wr_en,
    input  pt_dma_pkg::pt_wr_req_t pt_wr_req,
    output logic                   pt_wr_rdy,
    output pt_dma_pkg::pt_rd_rsp_t pt_rd_rsp,

    // Sticky reserved-tag violation
    output logic                   tag_error
);

    logic rd_pending;
    logic wr_pending;

    // ==============================
    // AFU request check
    // ==============================

    afu_tag_checker u_tag_checker (
        .clk        (clk),
        .reset_n    (reset_n),
        .afu_c0_req (afu_c0_req),
        .afu_c1_req (afu_c1_req),
        .tag_error  (tag_error)
    );

    // ==============================
    // Request injection
    // ==============================

    // Page-table reads merge into c0
    pt_read_injector u_rd_inj (
        .clk              (clk),
        .reset_n          (reset_n),
        .pt_rd_en         (pt_rd_en),
        .pt_rd_req        (pt_rd_req),
        .afu_c0_req       (afu_c0_req),
        .host_c0_alm_full (host_c0_alm_full),
        .pt_rd_rdy        (pt_rd_rdy),
        .rd_pending       (rd_pending),
        .host_c0_req      (host_c0_req)
    );

    // Page-table writes merge into c1
    pt_write_injector u_wr_inj (
        .clk              (clk),
        .reset_n          (reset_n),
        .pt_wr_en         (pt_wr_en),
        .pt_wr_req        (pt_wr_req),
        .afu_c1_req       (afu_c1_req),
        .host_c1_alm_full (host_c1_alm_full),
        .pt_wr_rdy        (pt_wr_rdy),
        .wr_pending       (wr_pending),
        .host_c1_req      (host_c1_req)
    );

    // ==============================
    // Response steering
    // ==============================

    host_rsp_steer u_rsp_steer (
        .host_c0_rsp (host_c0_rsp),
        .host_c1_rsp (host_c1_rsp),
        .pt_rd_rsp   (pt_rd_rsp),
        .afu_c0_rsp  (afu_c0_rsp),
        .afu_c1_rsp  (afu_c1_rsp)
    );

    // A pending injection asks the AFU to leave a slot free on its channel.
    // After a tag error both channels stay blocked until reset
    assign afu_c0_alm_full = host_c0_alm_full || rd_pending || tag_error;
    assign afu_c1_alm_full = host_c1_alm_full || wr_pending || tag_error;

endmodule

`default_nettype wire

// File: src/pt_read_injector.sv
`default_nettype none

module pt_read_injector (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   pt_rd_en,
    input  pt_dma_pkg::pt_rd_req_t pt_rd_req,
    input  pt_dma_pkg::c0_req_t    afu_c0_req,
    input  logic                   host_c0_alm_full,
    output logic                   pt_rd_rdy,
    output logic                   rd_pending,
    output pt_dma_pkg::c0_req_t    host_c0_req
);
    import pt_dma_pkg::*;

    inj_state_e           state;
    logic [CL_ADDR_W-1:0] rd_addr;
    logic [PT_TAG_W-1:0]  rd_tag;
    logic                 emit;
    c0_req_t              inj_req;

    // The AFU keeps priority on c0. The held read only goes out in a slot
    // the AFU leaves empty and while the host can still take requests
    assign emit = (state == INJ_PENDING) && !afu_c0_req.valid && !host_c0_alm_full;

    // One read at a time. The client may only strobe while ready is high
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= INJ_IDLE;
        end
        else
        begin
            case (state)
                INJ_IDLE:
                    if (pt_rd_en)
                        state <= INJ_PENDING;
                INJ_PENDING:
                    if (emit)
                        state <= INJ_IDLE;
                default:
                    state <= INJ_IDLE;
            endcase
        end
    end

    // Address and client tag are captured with the accepted strobe
    always_ff @(posedge clk)
    begin
        if (pt_rd_en && pt_rd_rdy)
        begin
            rd_addr <= pt_rd_req.addr;
            rd_tag  <= pt_rd_req.tag;
        end
    end

    // The client tag rides in the low mdata bits under the reserved tag
    always_comb
    begin
        inj_req       = '0;
        inj_req.valid = 1'b1;
        inj_req.op    = OP_RD_LINE;
        inj_req.addr  = rd_addr;
        inj_req.mdata = MDATA_TAG_VALUE | MDATA_W'(rd_tag);
    end

    assign host_c0_req = emit ? inj_req : afu_c0_req;

    assign pt_rd_rdy  = (state == INJ_IDLE);
    assign rd_pending = (state == INJ_PENDING);

endmodule

`default_nettype wire

// File: src/pt_write_injector.sv
`default_nettype none

module pt_write_injector (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   pt_wr_en,
    input  pt_dma_pkg::pt_wr_req_t pt_wr_req,
    input  pt_dma_pkg::c1_req_t    afu_c1_req,
    input  logic                   host_c1_alm_full,
    output logic                   pt_wr_rdy,
    output logic                   wr_pending,
    output pt_dma_pkg::c1_req_t    host_c1_req
);
    import pt_dma_pkg::*;

    inj_state_e             state;
    logic [CL_ADDR_W-1:0]   wr_addr;
    logic [LINE_DATA_W-1:0] wr_data;
    logic                   emit;
    c1_req_t                inj_req;

    // Every write is a single line, so any cycle without an AFU write is a
    // safe slot as long as the host is not backing up c1
    assign emit = (state == INJ_PENDING) && !afu_c1_req.valid && !host_c1_alm_full;

    // Idle until the client strobes, pending until the slot is found
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= INJ_IDLE;
        end
        else
        begin
            case (state)
                INJ_IDLE:
                    if (pt_wr_en)
                        state <= INJ_PENDING;
                INJ_PENDING:
                    if (emit)
                        state <= INJ_IDLE;
                default:
                    state <= INJ_IDLE;
            endcase
        end
    end

    // Line address and data held for the duration of the pending state
    always_ff @(posedge clk)
    begin
        if (pt_wr_en && pt_wr_rdy)
        begin
            wr_addr <= pt_wr_req.addr;
            wr_data <= pt_wr_req.data;
        end
    end

    // Write responses are absorbed, so the reserved tag alone is enough
    always_comb
    begin
        inj_req       = '0;
        inj_req.valid = 1'b1;
        inj_req.op    = OP_WR_LINE;
        inj_req.addr  = wr_addr;
        inj_req.mdata = MDATA_TAG_VALUE;
        inj_req.data  = wr_data;
    end

    assign host_c1_req = emit ? inj_req : afu_c1_req;

    assign pt_wr_rdy  = (state == INJ_IDLE);
    assign wr_pending = (state == INJ_PENDING);

endmodule

`default_nettype wire

// File: tests/tb_pt_dma_shim.sv
`default_nettype none

module tb_pt_dma_shim;
    timeunit 1ns;
    timeprecision 1ps;

    import pt_dma_pkg::*;

    localparam int CLK_PERIOD = 100;
    // The six tests together take well under a hundred cycles
    localparam int MAX_CYCLES = 400;
    localparam int READY_WAIT = 40;

    logic clk;
    logic reset_n;
    c0_req_t afu_c0_req;
    c1_req_t afu_c1_req;
    c0_rsp_t afu_c0_rsp;
    c1_rsp_t afu_c1_rsp;
    logic afu_c0_alm_full;
    logic afu_c1_alm_full;
    c0_req_t host_c0_req;
    c1_req_t host_c1_req;
    c0_rsp_t host_c0_rsp;
    c1_rsp_t host_c1_rsp;
    logic host_c0_alm_full;
    logic host_c1_alm_full;
    logic pt_rd_en;
    pt_rd_req_t pt_rd_req;
    logic pt_rd_rdy;
    logic pt_wr_en;
    pt_wr_req_t pt_wr_req;
    logic pt_wr_rdy;
    pt_rd_rsp_t pt_rd_rsp;
    logic tag_error;

    int unsigned lcg_state = 5768;
    int error_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;

    // The reference model state runs one step ahead of the checks at each falling edge
    logic exp_rd_pending = 1'b0;
    logic exp_wr_pending = 1'b0;
    logic exp_tag_error = 1'b0;
    logic [CL_ADDR_W-1:0] exp_rd_addr;
    logic [PT_TAG_W-1:0] exp_rd_tag;
    logic [CL_ADDR_W-1:0] exp_wr_addr;
    logic [LINE_DATA_W-1:0] exp_wr_data;

    // Injected requests seen on the host ports
    int rd_emits = 0;
    int wr_emits = 0;

    pt_dma_shim uut (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [CL_ADDR_W-1:0] random_addr();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi[31:22], lo};
    endfunction

    function automatic logic [LINE_DATA_W-1:0] random_data();
        logic [31:0] hi;
        hi = next_random();
        return {hi, next_random()};
    endfunction

    // The upper LCG bits are the better mixed ones, so mdata comes from them
    function automatic logic [MDATA_W-1:0] random_mdata(input logic reserved);
        logic [31:0] r;
        r = next_random();
        if (reserved)
            return r[31:16] | MDATA_TAG_MASK;
        return r[31:16] & ~MDATA_TAG_MASK;
    endfunction

    function automatic c0_req_t random_c0_req(input logic reserved);
        c0_req_t req;
        req.valid = 1'b1;
        req.op = OP_RD_LINE;
        req.addr = random_addr();
        req.mdata = random_mdata(reserved);
        return req;
    endfunction

    function automatic c1_req_t random_c1_req(input logic reserved);
        c1_req_t req;
        req.valid = 1'b1;
        req.op = OP_WR_LINE;
        req.addr = random_addr();
        req.mdata = random_mdata(reserved);
        req.data = random_data();
        return req;
    endfunction

    task automatic report_mismatch(input string what);
        $display("Mismatch at %0t ns: %s", $time, what);
        error_count++;
    endtask

    // The caller picks the clock edge on which these take effect
    task automatic clear_inputs();
        afu_c0_req <= '0;
        afu_c1_req <= '0;
        host_c0_rsp <= '0;
        host_c1_rsp <= '0;
        host_c0_alm_full <= 1'b0;
        host_c1_alm_full <= 1'b0;
        pt_rd_en <= 1'b0;
        pt_wr_en <= 1'b0;
    endtask

    task automatic issue_read();
        pt_rd_en <= 1'b1;
        pt_rd_req <= '{addr: random_addr(), tag: PT_TAG_W'(next_random() >> 24)};
    endtask

    task automatic issue_write();
        pt_wr_en <= 1'b1;
        pt_wr_req <= '{addr: random_addr(), data: random_data()};
    endtask

    task automatic wait_for_ready();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(pt_rd_rdy && pt_wr_rdy) && waited < READY_WAIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!(pt_rd_rdy && pt_wr_rdy))
        begin
            $display("Error at %0t ns: client ready never came back", $time);
            error_count++;
        end
    endtask

    // One idle cycle lets the falling-edge checks of the last stimulus finish
    task automatic end_test(input string name, input int errors_before);
        @(posedge clk);
        clear_inputs();
        @(posedge clk);
        tests_run++;
        if (error_count == errors_before)
        begin
            $display("Test %s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // ==============================
    // Checks
    // ==============================

    assert property (@(posedge clk) disable iff (!reset_n)
        ((afu_c0_req.valid && afu_c0_req.mdata[MDATA_W-1]) ||
         (afu_c1_req.valid && afu_c1_req.mdata[MDATA_W-1])) |=> tag_error)
    else report_mismatch("tag_error did not rise after a reserved-tag request");

    always @(negedge clk)
    begin : check_outputs
        logic rd_emit;
        logic wr_emit;
        logic c0_tagged;
        logic c1_tagged;
        c0_req_t exp_c0;
        c1_req_t exp_c1;

        rd_emit = exp_rd_pending && !afu_c0_req.valid && !host_c0_alm_full;
        wr_emit = exp_wr_pending && !afu_c1_req.valid && !host_c1_alm_full;
        c0_tagged = (host_c0_rsp.mdata & MDATA_TAG_MASK) == MDATA_TAG_VALUE;
        c1_tagged = (host_c1_rsp.mdata & MDATA_TAG_MASK) == MDATA_TAG_VALUE;
        exp_c0 = rd_emit ? c0_req_t'{1'b1, OP_RD_LINE, exp_rd_addr,
                                     MDATA_TAG_VALUE | MDATA_W'(exp_rd_tag)} : afu_c0_req;
        exp_c1 = wr_emit ? c1_req_t'{1'b1, OP_WR_LINE, exp_wr_addr, MDATA_TAG_VALUE,
                                     exp_wr_data} : afu_c1_req;

        assert (host_c0_req === exp_c0)
        else report_mismatch($sformatf("host_c0_req %h, expected %h", host_c0_req, exp_c0));
        assert (host_c1_req === exp_c1)
        else report_mismatch($sformatf("host_c1_req %h, expected %h", host_c1_req, exp_c1));
        assert (pt_rd_rdy === !exp_rd_pending && pt_wr_rdy === !exp_wr_pending)
        else report_mismatch("client ready does not follow the pending state");
        assert (tag_error === exp_tag_error)
        else report_mismatch($sformatf("tag_error %b, expected %b", tag_error, exp_tag_error));
        assert (afu_c0_alm_full === (host_c0_alm_full || exp_rd_pending || exp_tag_error))
        else report_mismatch("afu_c0_alm_full has the wrong value");
        assert (afu_c1_alm_full === (host_c1_alm_full || exp_wr_pending || exp_tag_error))
        else report_mismatch("afu_c1_alm_full has the wrong value");
        // Tagged responses belong to the client and all others to the AFU
        assert (pt_rd_rsp.valid === (host_c0_rsp.valid && c0_tagged))
        else report_mismatch("pt_rd_rsp.valid has the wrong value");
        if (host_c0_rsp.valid && c0_tagged)
            assert (pt_rd_rsp.tag === host_c0_rsp.mdata[PT_TAG_W-1:0] &&
                    pt_rd_rsp.data === host_c0_rsp.data)
            else report_mismatch("pt_rd_rsp tag or data differs from the host response");
        assert (c0_tagged ? !afu_c0_rsp.valid : afu_c0_rsp === host_c0_rsp)
        else report_mismatch($sformatf("afu_c0_rsp %h, host %h", afu_c0_rsp, host_c0_rsp));
        assert (c1_tagged ? !afu_c1_rsp.valid : afu_c1_rsp === host_c1_rsp)
        else report_mismatch($sformatf("afu_c1_rsp %h, host %h", afu_c1_rsp, host_c1_rsp));

        // A valid host request without an AFU request behind it was injected by the DUT
        if (host_c0_req.valid && !afu_c0_req.valid)
            rd_emits++;
        if (host_c1_req.valid && !afu_c1_req.valid)
            wr_emits++;

        // Next state as seen after the coming rising edge
        if (!reset_n)
        begin
            exp_rd_pending = 1'b0;
            exp_wr_pending = 1'b0;
            exp_tag_error = 1'b0;
        end
        else
        begin
            if (exp_rd_pending && rd_emit)
            begin
                exp_rd_pending = 1'b0;
            end
            else if (!exp_rd_pending && pt_rd_en)
            begin
                exp_rd_pending = 1'b1;
                exp_rd_addr = pt_rd_req.addr;
                exp_rd_tag = pt_rd_req.tag;
            end
            if (exp_wr_pending && wr_emit)
            begin
                exp_wr_pending = 1'b0;
            end
            else if (!exp_wr_pending && pt_wr_en)
            begin
                exp_wr_pending = 1'b1;
                exp_wr_addr = pt_wr_req.addr;
                exp_wr_data = pt_wr_req.data;
            end
            if ((afu_c0_req.valid && (afu_c0_req.mdata & MDATA_TAG_MASK) == MDATA_TAG_VALUE) ||
                (afu_c1_req.valid && (afu_c1_req.mdata & MDATA_TAG_MASK) == MDATA_TAG_VALUE))
                exp_tag_error = 1'b1;
        end
    end

    // ==============================
    // Tests
    // ==============================

    task automatic apply_reset();
        @(posedge clk);
        reset_n <= 1'b0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
    endtask

    initial
    begin
        int errs;
        int rd_before;
        int wr_before;
        reset_n = 1'b0;
        afu_c0_req = '0;
        afu_c1_req = '0;
        host_c0_rsp = '0;
        host_c1_rsp = '0;
        host_c0_alm_full = 1'b0;
        host_c1_alm_full = 1'b0;
        pt_rd_en = 1'b0;
        pt_rd_req = '0;
        pt_wr_en = 1'b0;
        pt_wr_req = '0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;

        // Untagged traffic in both directions passes untouched
        errs = error_count;
        repeat (8)
        begin
            @(posedge clk);
            afu_c0_req <= random_c0_req(1'b0);
            afu_c1_req <= random_c1_req(1'b0);
            host_c0_rsp <= '{1'b1, random_mdata(1'b0), random_data()};
            host_c1_rsp <= '{1'b1, random_mdata(1'b0)};
        end
        end_test("passthrough", errs);

        errs = error_count;
        rd_before = rd_emits;
        @(posedge clk);
        issue_read();
        @(posedge clk);
        pt_rd_en <= 1'b0;
        wait_for_ready();
        @(posedge clk);
        assert (rd_emits == rd_before + 1)
        else report_mismatch("read injection was not emitted exactly once");
        end_test("read injection", errs);

        // Busy AFU, then host back-pressure, hold both injections back
        errs = error_count;
        rd_before = rd_emits;
        wr_before = wr_emits;
        @(posedge clk);
        issue_read();
        issue_write();
        afu_c0_req <= random_c0_req(1'b0);
        afu_c1_req <= random_c1_req(1'b0);
        repeat (4)
        begin
            @(posedge clk);
            pt_rd_en <= 1'b0;
            pt_wr_en <= 1'b0;
            afu_c0_req <= random_c0_req(1'b0);
            afu_c1_req <= random_c1_req(1'b0);
        end
        @(posedge clk);
        afu_c0_req <= '0;
        afu_c1_req <= '0;
        host_c0_alm_full <= 1'b1;
        host_c1_alm_full <= 1'b1;
        repeat (3) @(posedge clk);
        host_c0_alm_full <= 1'b0;
        @(posedge clk);
        host_c1_alm_full <= 1'b0;
        wait_for_ready();
        @(posedge clk);
        assert (rd_emits == rd_before + 1 && wr_emits == wr_before + 1)
        else report_mismatch("held injections were not emitted exactly once each");
        end_test("priority and back-pressure", errs);

        errs = error_count;
        wr_before = wr_emits;
        @(posedge clk);
        issue_write();
        @(posedge clk);
        pt_wr_en <= 1'b0;
        wait_for_ready();
        @(posedge clk);
        assert (wr_emits == wr_before + 1)
        else report_mismatch("write injection was not emitted exactly once");
        end_test("write injection", errs);

        errs = error_count;
        for (int i = 0; i < 6; i++)
        begin
            @(posedge clk);
            host_c0_rsp <= '{1'b1, random_mdata(i % 2 == 0), random_data()};
            host_c1_rsp <= '{1'b1, random_mdata(i % 3 != 2)};
        end
        end_test("response steering", errs);

        // Each channel raises the error once, and a reset clears it again
        errs = error_count;
        for (int ch = 0; ch < 2; ch++)
        begin
            @(posedge clk);
            if (ch == 0)
                afu_c0_req <= random_c0_req(1'b1);
            else
                afu_c1_req <= random_c1_req(1'b1);
            @(posedge clk);
            clear_inputs();
            repeat (2) @(posedge clk);
            @(negedge clk);
            assert (tag_error && afu_c0_alm_full && afu_c1_alm_full)
            else report_mismatch("tag error or forced almost-full not held high");
            apply_reset();
            @(negedge clk);
            assert (!tag_error && !afu_c0_alm_full && !afu_c1_alm_full)
            else report_mismatch("reset did not clear the tag error");
        end
        end_test("tag error", errs);

        $display("Summary: %0d run, %0d failing, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0 && tests_failed == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
